// File: verilog/t11_pkg.sv
/* Shared word width, operation codes and flag update rules for the T11 execute datapath.
   Imported by wildcard into each module header that needs them. */

`default_nettype none

package t11_pkg;

   localparam int data_w = 16;          // machine word

   // operation codes strobed in from outside
   typedef enum logic [3:0]
   {
      op_mov  = 4'd0,
      op_ldi  = 4'd1,
      op_add  = 4'd2,
      op_sub  = 4'd3,
      op_cmp  = 4'd4,                   // src - dst, no write back
      op_bic  = 4'd5,
      op_bis  = 4'd6,
      op_xor  = 4'd7,
      op_com  = 4'd8,
      op_inc  = 4'd9,
      op_dec  = 4'd10,
      op_neg  = 4'd11,
      op_asr  = 4'd12,
      op_ror  = 4'd13,                  // through C
      op_swab = 4'd14
   } t11_op_e;

   // how N Z V C get updated
   typedef enum logic [2:0]
   {
      fl_move   = 3'd0,
      fl_arith  = 3'd1,
      fl_incdec = 3'd2,
      fl_com    = 3'd3,
      fl_neg    = 3'd4,
      fl_shift  = 3'd5,
      fl_swab   = 3'd6
   } t11_flag_e;

endpackage

`default_nettype wire

// File: verilog/t11_op_decode.sv
/* Operation decode: maps a strobed opcode onto ALU term selects, carry-in and flag rule,
   registered for the single execute stage. */

`timescale 1ns/1ps
`default_nettype none

module t11_op_decode import t11_pkg::*;
(
   input  logic      vm_clk_p,
   input  logic      reset,
   input  logic      op_stb,
   input  t11_op_e   op,
   output logic      stg_valid,
   output logic      x00,
   output logic      x01,
   output logic      x10,
   output logic      x11,
   output logic      y01,
   output logic      y10,
   output logic      y11,
   output logic      y_one,
   output logic      carry_in,
   output logic      shift_right,
   output logic      rotate,
   output logic      swap,
   output logic      invert_x,
   output t11_flag_e flag_rule,
   output logic      write_en
);

logic [6:0]  terms_d;                   // {x00,x01,x10,x11,y01,y10,y11}
logic        y_one_d;
logic        carry_in_d;
logic        shift_right_d;
logic        rotate_d;
logic        swap_d;
logic        invert_x_d;
t11_flag_e   flag_d;
logic        write_d;

always_comb
begin
   terms_d       = 7'b0000_000;
   y_one_d       = 1'b0;
   carry_in_d    = 1'b0;
   shift_right_d = 1'b0;
   rotate_d      = 1'b0;
   swap_d        = 1'b0;
   invert_x_d    = 1'b0;
   flag_d        = fl_move;
   write_d       = 1'b1;

   case (op)
      op_mov, op_ldi: terms_d = 7'b0011_000;      // half sum is y
      op_add:
      begin
         terms_d = 7'b0110_001;                   // x^y, generate on x&y
         flag_d  = fl_arith;
      end
      op_sub:
      begin
         terms_d    = 7'b1001_100;                // x xnor y, generate on x&~y
         carry_in_d = 1'b1;
         flag_d     = fl_arith;
      end
      op_cmp:
      begin
         // y + ~x + 1 with x inverted ahead of the terms
         terms_d    = 7'b0110_001;
         invert_x_d = 1'b1;
         carry_in_d = 1'b1;
         flag_d     = fl_arith;
         write_d    = 1'b0;
      end
      op_bic: terms_d = 7'b0100_000;              // x&~y, no carries
      op_bis: terms_d = 7'b0111_000;
      op_xor: terms_d = 7'b0110_000;
      op_com:
      begin
         terms_d    = 7'b0101_000;                // pass inverted x
         invert_x_d = 1'b1;
         flag_d     = fl_com;
      end
      op_inc:
      begin
         terms_d = 7'b0110_001;
         y_one_d = 1'b1;
         flag_d  = fl_incdec;
      end
      op_dec:
      begin
         terms_d    = 7'b1001_100;
         y_one_d    = 1'b1;
         carry_in_d = 1'b1;
         flag_d     = fl_incdec;
      end
      op_neg:
      begin
         terms_d    = 7'b0101_000;                // ~x incremented by carry-in
         invert_x_d = 1'b1;
         carry_in_d = 1'b1;
         flag_d     = fl_neg;
      end
      op_asr:
      begin
         shift_right_d = 1'b1;
         flag_d        = fl_shift;
      end
      op_ror:
      begin
         shift_right_d = 1'b1;
         rotate_d      = 1'b1;
         flag_d        = fl_shift;
      end
      op_swab:
      begin
         swap_d = 1'b1;
         flag_d = fl_swab;
      end
      default: write_d = 1'b0;                    // unused code, no write
   endcase
end

always_ff @(posedge vm_clk_p or posedge reset)
begin
   if (reset)
   begin
      stg_valid <= 1'b0;
      {x00, x01, x10, x11, y01, y10, y11} <= 7'b0000_000;
      y_one       <= 1'b0;
      carry_in    <= 1'b0;
      shift_right <= 1'b0;
      rotate      <= 1'b0;
      swap        <= 1'b0;
      invert_x    <= 1'b0;
      flag_rule   <= fl_move;
      write_en    <= 1'b0;
   end
   else
   begin
      stg_valid <= op_stb;                        // one cycle per strobe
      if (op_stb)
      begin
         {x00, x01, x10, x11, y01, y10, y11} <= terms_d;
         y_one       <= y_one_d;
         carry_in    <= carry_in_d;
         shift_right <= shift_right_d;
         rotate      <= rotate_d;
         swap        <= swap_d;
         invert_x    <= invert_x_d;
         flag_rule   <= flag_d;
         write_en    <= write_d;
      end
   end
end

endmodule

`default_nettype wire

// File: verilog/t11_alu.sv
/* Combinational ALU: half-sum and half-carry from selected X/Y terms, carries by lookahead
   in 4-bit groups, plus shift, rotate and byte swap paths and N Z V C generation. */

`timescale 1ns/1ps
`default_nettype none

module t11_alu import t11_pkg::*;
(
   input  logic [data_w-1:0] stg_x,
   input  logic [data_w-1:0] stg_y,
   input  logic              x00,
   input  logic              x01,
   input  logic              x10,
   input  logic              x11,
   input  logic              y01,
   input  logic              y10,
   input  logic              y11,
   input  logic              y_one,
   input  logic              carry_in,
   input  logic              shift_right,
   input  logic              rotate,
   input  logic              swap,
   input  logic              invert_x,
   input  logic              carry_flag,
   input  t11_flag_e         flag_rule,
   output logic [data_w-1:0] alu_result,
   output logic [3:0]        alu_flags
);

logic [data_w-1:0] x;
logic [data_w-1:0] y;
logic [data_w-1:0] ax;                  // half sum
logic [data_w-1:0] ay;                  // half carry
logic [data_w:0]   ac;                  // carry chain
logic              nf, zf, vf, cf;

assign x = invert_x ? ~stg_x : stg_x;
assign y = y_one ? data_w'(1) : stg_y;

assign ax = ({data_w{x00}} & ~y & ~x)
          | ({data_w{x01}} & ~y &  x)
          | ({data_w{x10}} &  y & ~x)
          | ({data_w{x11}} &  y &  x);

assign ay = ({data_w{y01}} & ~y &  x)
          | ({data_w{y10}} &  y & ~x)
          | ({data_w{y11}} &  y &  x);

// each group sees only the carry into its lowest bit
always_comb
begin
   logic prop;
   logic gen;

   ac[0] = carry_in;
   for (int g = 0; g < data_w / 4; g++)
   begin
      for (int k = 0; k < 4; k++)
      begin
         prop = 1'b1;
         gen  = 1'b0;
         for (int j = k; j >= 0; j--)
         begin
            gen  = gen | (ay[4*g+j] & prop);
            prop = prop & ax[4*g+j];
         end
         ac[4*g+k+1] = gen | (prop & ac[4*g]);
      end
   end
end

always_comb
begin
   if (swap)
      alu_result = {stg_x[7:0], stg_x[15:8]};
   else if (shift_right)
      alu_result = {rotate ? carry_flag : stg_x[data_w-1], stg_x[data_w-1:1]};
   else
      alu_result = ax ^ ac[data_w-1:0];
end

assign nf = swap ? alu_result[7] : alu_result[data_w-1];
assign zf = swap ? (alu_result[7:0] == 8'h00) : (alu_result == '0);

always_comb
begin
   vf = 1'b0;
   cf = carry_flag;                               // kept unless the rule says otherwise
   case (flag_rule)
      fl_arith:
      begin
         vf = ac[data_w] ^ ac[data_w-1];
         cf = ac[data_w] ^ carry_in;              // borrow when subtracting
      end
      fl_incdec: vf = ac[data_w] ^ ac[data_w-1];
      fl_com:    cf = 1'b1;
      fl_neg:
      begin
         cf = |alu_result;
         vf = (alu_result == {1'b1, {(data_w-1){1'b0}}});
      end
      fl_shift:
      begin
         cf = stg_x[0];
         vf = nf ^ stg_x[0];
      end
      fl_swab:   cf = 1'b0;
      default:   vf = 1'b0;                       // move rule
   endcase
end

assign alu_flags = {nf, zf, vf, cf};

endmodule

`default_nettype wire

// File: verilog/t11_reg_block.sv
/* General registers and PSW with the operand stage; captures operands on a strobe, writes
   back the ALU result one cycle later and forwards it to a following read. */

`timescale 1ns/1ps
`default_nettype none

module t11_reg_block import t11_pkg::*;
#(
   parameter int reg_count = 8
)
(
   input  logic                         vm_clk_p,
   input  logic                         reset,
   input  logic                         op_stb,
   input  logic [$clog2(reg_count)-1:0] src_sel,
   input  logic [$clog2(reg_count)-1:0] dst_sel,
   input  logic [data_w-1:0]            imm,
   input  logic                         ldi_sel,
   input  logic                         stg_valid,
   input  logic                         write_en,
   input  logic [data_w-1:0]            alu_result,
   input  logic [3:0]                   alu_flags,
   output logic [data_w-1:0]            stg_x,
   output logic [data_w-1:0]            stg_y,
   output logic                         carry_flag,
   output logic                         res_stb,
   output logic [data_w-1:0]            res_data,
   output logic [$clog2(reg_count)-1:0] res_sel,
   output logic                         res_wr,
   output logic [3:0]                   psw_flags
);

localparam int sel_w = $clog2(reg_count);

logic [data_w-1:0] regs [reg_count];
logic [sel_w-1:0]  stg_sel;             // destination of the staged op
logic              fwd_dst;
logic              fwd_src;
logic [data_w-1:0] dst_word;
logic [data_w-1:0] src_word;

// write landing at this edge is visible to the op sampled here
assign fwd_dst = stg_valid & write_en & (stg_sel == dst_sel);
assign fwd_src = stg_valid & write_en & (stg_sel == src_sel);

assign dst_word = fwd_dst ? alu_result : regs[dst_sel];
assign src_word = fwd_src ? alu_result : regs[src_sel];

always_ff @(posedge vm_clk_p or posedge reset)
begin
   if (reset)
   begin
      for (int i = 0; i < reg_count; i++)
         regs[i] <= '0;
      psw_flags <= 4'b0000;
      res_stb   <= 1'b0;
      res_wr    <= 1'b0;
   end
   else
   begin
      res_stb <= stg_valid;
      res_wr  <= stg_valid & write_en;            // low for compare
      if (stg_valid)
      begin
         psw_flags <= alu_flags;                  // N Z V C
         if (write_en)
            regs[stg_sel] <= alu_result;
      end
   end
end

always_ff @(posedge vm_clk_p)
begin
   if (op_stb)
   begin
      stg_x      <= dst_word;
      stg_y      <= ldi_sel ? imm : src_word;
      stg_sel    <= dst_sel;
      carry_flag <= stg_valid ? alu_flags[0] : psw_flags[0];
   end

   if (stg_valid)
   begin
      res_data <= alu_result;
      res_sel  <= stg_sel;
   end
end

endmodule

`default_nettype wire

// File: verilog/t11_exec.sv
/* Top of the T11 execute datapath. Takes one strobed operation per cycle and returns
   its result, destination and flags one cycle later. */

`timescale 1ns/1ps
`default_nettype none

module t11_exec import t11_pkg::*;
#(
   parameter int reg_count = 8
)
(
   input  logic                         vm_clk_p,
   input  logic                         reset,
   input  logic                         op_stb,
   input  t11_op_e                      op,
   input  logic [$clog2(reg_count)-1:0] src_sel,
   input  logic [$clog2(reg_count)-1:0] dst_sel,
   input  logic [data_w-1:0]            imm,
   output logic                         res_stb,
   output logic [data_w-1:0]            res_data,
   output logic [$clog2(reg_count)-1:0] res_sel,
   output logic                         res_wr,
   output logic [3:0]                   psw_flags
);

logic              stg_valid;
logic              x00, x01, x10, x11;   // half sum terms
logic              y01, y10, y11;        // half carry terms
logic              y_one;
logic              carry_in;
logic              shift_right;
logic              rotate;
logic              swap;
logic              invert_x;
t11_flag_e         flag_rule;
logic              write_en;
logic              ldi_sel;
logic [data_w-1:0] stg_x;
logic [data_w-1:0] stg_y;
logic              carry_flag;
logic [data_w-1:0] alu_result;
logic [3:0]        alu_flags;

assign ldi_sel = (op == op_ldi);          // immediate onto Y

t11_op_decode u_decode
(
   .vm_clk_p (vm_clk_p), .reset (reset), .op_stb (op_stb), .op (op),
   .stg_valid (stg_valid),
   .x00 (x00), .x01 (x01), .x10 (x10), .x11 (x11),
   .y01 (y01), .y10 (y10), .y11 (y11), .y_one (y_one),
   .carry_in (carry_in), .shift_right (shift_right), .rotate (rotate),
   .swap (swap), .invert_x (invert_x), .flag_rule (flag_rule), .write_en (write_en)
);

t11_reg_block #(.reg_count (reg_count)) u_regs
(
   .vm_clk_p (vm_clk_p), .reset (reset), .op_stb (op_stb),
   .src_sel (src_sel), .dst_sel (dst_sel), .imm (imm), .ldi_sel (ldi_sel),
   .stg_valid (stg_valid), .write_en (write_en),
   .alu_result (alu_result), .alu_flags (alu_flags),
   .stg_x (stg_x), .stg_y (stg_y), .carry_flag (carry_flag),
   .res_stb (res_stb), .res_data (res_data), .res_sel (res_sel),
   .res_wr (res_wr), .psw_flags (psw_flags)
);

t11_alu u_alu
(
   .stg_x (stg_x), .stg_y (stg_y),
   .x00 (x00), .x01 (x01), .x10 (x10), .x11 (x11),
   .y01 (y01), .y10 (y10), .y11 (y11), .y_one (y_one),
   .carry_in (carry_in), .shift_right (shift_right), .rotate (rotate),
   .swap (swap), .invert_x (invert_x), .carry_flag (carry_flag),
   .flag_rule (flag_rule), .alu_result (alu_result), .alu_flags (alu_flags)
);

endmodule

`default_nettype wire

// File: testbench/t11_exec_checker.sv
/* Concurrent assertions on the execute datapath ports. Attached to t11_exec by bind from
   the testbench top; assert_errs counts failures for the final verdict. */

`timescale 1ns/1ps
`default_nettype none

module t11_exec_checker import t11_pkg::*;
(
   input logic              vm_clk_p,
   input logic              reset,
   input logic              op_stb,
   input logic              res_stb,
   input logic [data_w-1:0] res_data,
   input logic [3:0]        psw_flags
);

int assert_errs = 0;

// staged at the sampling edge, result registered one edge later
strobe_gives_result: assert property (@(posedge vm_clk_p) disable iff (reset)
   op_stb |-> ##2 res_stb)
   else
   begin
      assert_errs++;
      $error("res_stb missing one cycle after op_stb");
   end

result_needs_strobe: assert property (@(posedge vm_clk_p) disable iff (reset)
   res_stb |-> $past(op_stb, 2))
   else
   begin
      assert_errs++;
      $error("res_stb without op_stb one cycle before");
   end

result_known: assert property (@(posedge vm_clk_p) disable iff (reset)
   res_stb |-> !$isunknown(res_data))
   else
   begin
      assert_errs++;
      $error("res_data has unknown bits during res_stb");
   end

// flags only move together with a result
psw_held: assert property (@(posedge vm_clk_p) disable iff (reset)
   !res_stb |-> $stable(psw_flags))
   else
   begin
      assert_errs++;
      $error("psw_flags changed while res_stb was low");
   end

endmodule

`default_nettype wire

// File: testbench/t11_exec_monitor.sv
/* Watches the DUT ports, keeps shadow registers and PSW, and compares every result
   against a reference model of the flag rules. Counts are read by the testbench top. */

`timescale 1ns/1ps
`default_nettype none

module t11_exec_monitor import t11_pkg::*;
#(
   parameter int reg_count = 8
)
(
   input  logic                         vm_clk_p,
   input  logic                         reset,
   input  logic                         op_stb,
   input  t11_op_e                      op,
   input  logic [$clog2(reg_count)-1:0] src_sel,
   input  logic [$clog2(reg_count)-1:0] dst_sel,
   input  logic [data_w-1:0]            imm,
   input  logic                         res_stb,
   input  logic [data_w-1:0]            res_data,
   input  logic [$clog2(reg_count)-1:0] res_sel,
   input  logic                         res_wr,
   input  logic [3:0]                   psw_flags,
   output int                           value_errs,
   output int                           proto_errs,
   output int                           checked,
   output int                           outstanding
);

localparam int msb = data_w - 1;
localparam logic [data_w-1:0] sign_word = {1'b1, {(data_w-1){1'b0}}};

logic [data_w-1:0] shadow [reg_count];
logic [3:0]        shadow_psw;          // N Z V C
int                cycle;
bit                seen_stb;
int                value_cnt = 0;
int                proto_cnt = 0;
int                check_cnt = 0;
int                due_q[$];            // negedge at which the result shows
logic [data_w+4:0] exp_q[$];            // {wr, flags, result}
logic [data_w-1:0] sel_q[$];

assign value_errs  = value_cnt;
assign proto_errs  = proto_cnt;
assign checked     = check_cnt;

// returns {wr, n, z, v, c, result}
function automatic logic [data_w+4:0] ref_exec(input t11_op_e code, input logic [data_w-1:0] d,
   input logic [data_w-1:0] s, input logic [data_w-1:0] k, input logic c_old);
   logic [data_w:0]   wide;
   logic [data_w-1:0] r;
   logic              n, z, v, c, wr, low_byte;

   r        = '0;
   v        = 1'b0;
   c        = c_old;
   wr       = 1'b1;
   low_byte = 1'b0;
   case (code)
      op_mov: r = s;
      op_ldi: r = k;
      op_add:
      begin
         wide = {1'b0, d} + {1'b0, s};
         r    = wide[msb:0];
         c    = wide[data_w];                           // carry out
         v    = (d[msb] == s[msb]) && (r[msb] != d[msb]);
      end
      op_sub:
      begin
         r = d - s;
         c = (d < s);                                   // borrow
         v = (d[msb] != s[msb]) && (r[msb] != d[msb]);
      end
      op_cmp:
      begin
         r  = s - d;
         c  = (s < d);
         v  = (s[msb] != d[msb]) && (r[msb] != s[msb]);
         wr = 1'b0;
      end
      op_bic: r = d & ~s;
      op_bis: r = d | s;
      op_xor: r = d ^ s;
      op_com:
      begin
         r = ~d;
         c = 1'b1;
      end
      op_inc:
      begin
         r = d + 1'b1;
         v = (d == ~sign_word);
      end
      op_dec:
      begin
         r = d - 1'b1;
         v = (d == sign_word);
      end
      op_neg:
      begin
         r = '0 - d;
         c = (r != '0);
         v = (r == sign_word);
      end
      op_asr, op_ror:
      begin
         r = {(code == op_ror) ? c_old : d[msb], d[msb:1]};
         c = d[0];
         v = r[msb] ^ d[0];
      end
      op_swab:
      begin
         r        = {d[7:0], d[15:8]};
         c        = 1'b0;
         low_byte = 1'b1;
      end
      default: wr = 1'b0;
   endcase
   n = low_byte ? r[7] : r[msb];
   z = low_byte ? (r[7:0] == 8'h00) : (r == '0);
   ref_exec = {wr, n, z, v, c, r};
endfunction

task automatic compare_field(input string name, input logic [data_w-1:0] expected,
                             input logic [data_w-1:0] actual);
   if (actual !== expected)
   begin
      value_cnt = value_cnt + 1;
      $display("FAILED %0t %s expected %h got %h", $time, name, expected, actual);
   end
endtask

// negedge sampling, inputs and outputs are both settled here
always @(negedge vm_clk_p)
begin
   logic [data_w+4:0] exp;

   if (reset)
   begin
      cycle      = 0;
      seen_stb   = 1'b0;
      shadow_psw = 4'b0000;
      for (int i = 0; i < reg_count; i++)
         shadow[i] = '0;
      due_q.delete();
      exp_q.delete();
      sel_q.delete();
   end
   else
   begin
      cycle = cycle + 1;
      if (!seen_stb)
         compare_field("psw_flags", '0, data_w'(psw_flags));   // idle after reset
      if (due_q.size() > 0 && due_q[0] == cycle)
      begin
         exp = exp_q.pop_front();
         if (res_stb !== 1'b1)
         begin
            proto_cnt = proto_cnt + 1;
            $display("ERROR at %0t: no res_stb one cycle after a sampled strobe", $time);
         end
         else
         begin
            compare_field("res_data", exp[msb:0], res_data);
            compare_field("res_sel", sel_q[0], data_w'(res_sel));
            compare_field("res_wr", data_w'(exp[data_w+4]), data_w'(res_wr));
            compare_field("psw_flags", data_w'(exp[data_w+3:data_w]), data_w'(psw_flags));
            check_cnt = check_cnt + 1;
         end
         void'(due_q.pop_front());
         void'(sel_q.pop_front());
      end
      else if (res_stb !== 1'b0)
      begin
         proto_cnt = proto_cnt + 1;
         $display("ERROR at %0t: res_stb high with no strobe one cycle before", $time);
      end

      if (op_stb === 1'b1)
      begin
         seen_stb = 1'b1;
         exp = ref_exec(op, shadow[dst_sel], shadow[src_sel], imm, shadow_psw[0]);
         if (exp[data_w+4])
            shadow[dst_sel] = exp[msb:0];
         shadow_psw = exp[data_w+3:data_w];
         due_q.push_back(cycle + 2);                    // sampled next edge, result one later
         exp_q.push_back(exp);
         sel_q.push_back(data_w'(dst_sel));
      end
   end
   outstanding = due_q.size();
end

endmodule

`default_nettype wire

// File: testbench/tb_t11_exec.sv
/* Testbench top for the execute datapath: clock, reset, LFSR driven operations and watchdog.
   Binds the assertion checker and collects the monitor's error counts for the verdict. */

`timescale 1ns/1ps
`default_nettype none

module tb_t11_exec import t11_pkg::*; ();

localparam int reg_count    = 8;
localparam int sel_w        = $clog2(reg_count);
localparam int period       = 100;
localparam int reset_cycles = 5;
localparam int n_rand       = 400;
localparam int watchdog_ns  = (reset_cycles + 2 * reg_count + n_rand + 20) * period * 2;

logic              vm_clk_p;
logic              reset;
logic              op_stb;
t11_op_e           op;
logic [sel_w-1:0]  src_sel;
logic [sel_w-1:0]  dst_sel;
logic [data_w-1:0] imm;
logic              res_stb;
logic [data_w-1:0] res_data;
logic [sel_w-1:0]  res_sel;
logic              res_wr;
logic [3:0]        psw_flags;
int                value_errs;
int                proto_errs;
int                checked;
int                outstanding;
int                strobes;
logic [15:0]       lfsr_state;

t11_exec #(.reg_count (reg_count)) DUT
(
   .vm_clk_p (vm_clk_p), .reset (reset), .op_stb (op_stb), .op (op),
   .src_sel (src_sel), .dst_sel (dst_sel), .imm (imm),
   .res_stb (res_stb), .res_data (res_data), .res_sel (res_sel),
   .res_wr (res_wr), .psw_flags (psw_flags)
);

t11_exec_monitor #(.reg_count (reg_count)) u_monitor
(
   .vm_clk_p (vm_clk_p), .reset (reset), .op_stb (op_stb), .op (op),
   .src_sel (src_sel), .dst_sel (dst_sel), .imm (imm),
   .res_stb (res_stb), .res_data (res_data), .res_sel (res_sel),
   .res_wr (res_wr), .psw_flags (psw_flags),
   .value_errs (value_errs), .proto_errs (proto_errs),
   .checked (checked), .outstanding (outstanding)
);

bind t11_exec t11_exec_checker u_checker
(
   .vm_clk_p (vm_clk_p), .reset (reset), .op_stb (op_stb), .res_stb (res_stb),
   .res_data (res_data), .psw_flags (psw_flags)
);

initial
begin
   vm_clk_p = 1'b0;
   forever #(period / 2) vm_clk_p = ~vm_clk_p;
end

// galois form, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
   lfsr_next = state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
endfunction

task automatic take_bits(input int count, output logic [data_w-1:0] bits);
   bits = '0;
   for (int i = 0; i < count; i++)
   begin
      bits       = {bits[data_w-2:0], lfsr_state[0]};   // one step per bit
      lfsr_state = lfsr_next(lfsr_state);
   end
endtask

task automatic issue(input t11_op_e code, input logic [sel_w-1:0] src,
                     input logic [sel_w-1:0] dst, input logic [data_w-1:0] value);
   @(posedge vm_clk_p);
   #10;
   op_stb  = 1'b1;
   op      = code;
   src_sel = src;
   dst_sel = dst;
   imm     = value;
   strobes = strobes + 1;
endtask

task automatic idle();
   @(posedge vm_clk_p);
   #10;
   op_stb = 1'b0;
endtask

initial
begin
   logic [data_w-1:0] pick;
   logic [data_w-1:0] code_bits;
   logic [data_w-1:0] s_bits;
   logic [data_w-1:0] d_bits;
   logic [data_w-1:0] value;
   t11_op_e           code;
   int                issued;
   int                other_errs;
   int                assert_errs;

   reset      = 1'b1;
   op_stb     = 1'b0;
   op         = op_mov;
   src_sel    = '0;
   dst_sel    = '0;
   imm        = '0;
   strobes    = 0;
   issued     = 0;
   other_errs = 0;
   lfsr_state = 16'd63613;
   repeat (reset_cycles) @(posedge vm_clk_p);
   #10;
   reset = 1'b0;

   for (int r = 0; r < reg_count; r++)
   begin
      take_bits(16, value);
      issue(op_ldi, '0, sel_w'(r), value);
   end
   for (int r = 0; r < reg_count; r++)
      issue(op_mov, sel_w'(r), sel_w'(r), '0);          // read back each load

   while (issued < n_rand)
   begin
      take_bits(2, pick);
      if (pick[1:0] != 2'b00)                           // strobe about 3 of 4 cycles
      begin
         take_bits(4, code_bits);
         take_bits(sel_w, s_bits);
         take_bits(sel_w, d_bits);
         take_bits(16, value);
         code = (code_bits[3:0] == 4'hf) ? op_add : t11_op_e'(code_bits[3:0]);
         issue(code, s_bits[sel_w-1:0], d_bits[sel_w-1:0], value);
         issued = issued + 1;
      end
      else
         idle();
   end
   idle();

   wait (outstanding == 0);
   @(negedge vm_clk_p);
   if (strobes != checked)
   begin
      $display("ERROR: %0d operations were strobed but %0d results were checked",
               strobes, checked);
      other_errs = other_errs + 1;
   end
   assert_errs = DUT.u_checker.assert_errs;
   $display("errors: %0d value, %0d protocol, %0d assertion, %0d other; %0d results checked",
            value_errs, proto_errs, assert_errs, other_errs, checked);
   if (value_errs + proto_errs + assert_errs + other_errs == 0)
      $display("Testbench passed");
   else
      $display("Testbench failed");
   $finish;
end

initial
begin
   #(watchdog_ns);
   $display("ERROR: watchdog expired before all results came back from the DUT");
   $display("Testbench failed");
   $finish;
end

endmodule

`default_nettype wire

// File: build.f
verilog/t11_pkg.sv
verilog/t11_op_decode.sv
verilog/t11_alu.sv
verilog/t11_reg_block.sv
verilog/t11_exec.sv
testbench/t11_exec_checker.sv
testbench/t11_exec_monitor.sv
testbench/tb_t11_exec.sv
